// File: Makefile
# Verilator simulation of the LSU subsystem

VERILATOR ?= verilator
TOP       ?= lsu_tb
SIM_DIR   ?= sim_build
LOG       ?= sim.log
FLIST     ?= list.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(SIM_DIR)
	./$(SIM_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(SIM_DIR) $(LOG)

// File: bench/lsu_tb.sv
`include "lsu_defines.svh"

module lsu_tb;

    logic               clk;
    logic               rst;
    lsu_pkg::lsu_word_t rdata;
    lsu_pkg::lsu_word_t wdata;
    lsu_pkg::lsu_word_t addr;
    lsu_pkg::lsu_mask_t mask;
    logic               r_en;
    logic               w_en;
    logic               finish;

    logic [31:0]        lfsr;
    lsu_pkg::lsu_word_t shadow [`LSU_MEM_WORDS];
    lsu_pkg::lsu_word_t exp_word;
    logic               load_pending;
    int                 fin_cnt;
    int                 err_cnt;
    int                 timeout_cnt;

    lsu_top i_lsu_top (
        .clk    (clk),
        .rst    (rst),
        .rdata  (rdata),
        .wdata  (wdata),
        .addr   (addr),
        .mask   (mask),
        .r_en   (r_en),
        .w_en   (w_en),
        .finish (finish)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32 22 2 1, one step per bit
    function automatic lsu_pkg::lsu_word_t take_bits(input int n);
        lsu_pkg::lsu_word_t val;
        logic               fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // byte lane b takes source byte b - off, lanes past the top are dropped
    function automatic lsu_pkg::lsu_word_t store_ref(input lsu_pkg::lsu_word_t old,
                                                     input lsu_pkg::lsu_word_t data,
                                                     input lsu_pkg::lsu_mask_t m,
                                                     input lsu_pkg::lsu_off_t off);
        lsu_pkg::lsu_word_t res;
        int                 src;
        res = old;
        for (int b = 0; b < 4; b++) begin
            src = b - int'(off);
            if (src >= 0 && m[src]) begin
                res[8*b +: 8] = data[8*src +: 8];
            end
        end
        return res;
    endfunction

    // zero fill from the top
    function automatic lsu_pkg::lsu_word_t load_ref(input lsu_pkg::lsu_word_t word,
                                                    input lsu_pkg::lsu_off_t off);
        lsu_pkg::lsu_word_t res;
        int                 src;
        res = '0;
        for (int b = 0; b < 4; b++) begin
            src = b + int'(off);
            if (src < 4) begin
                res[8*b +: 8] = word[8*src +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string what, input lsu_pkg::lsu_word_t got,
                              input lsu_pkg::lsu_word_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            err_cnt++;
            $display("** Error at %0t: %s saw %0d finish cycles, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    // counts finish cycles and checks load data while finish is high
    always @(negedge clk) begin
        if (finish) begin
            fin_cnt++;
            if (load_pending) begin
                check_word("load", rdata, exp_word);
            end
        end
    end

    task automatic wait_finish(input string what, input int start);
        int cycles;
        cycles = 0;
        while (fin_cnt == start && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        if (fin_cnt == start) begin
            timeout_cnt++;
            $display("The %s at time %0t got no finish pulse within 50 cycles.", what, $time);
        end else begin
            // a few idle cycles expose a doubled pulse
            repeat (3) @(posedge clk);
            check_count(what, fin_cnt - start, 1);
        end
        #2;
    endtask

    task automatic do_store(input lsu_pkg::lsu_word_t a, input lsu_pkg::lsu_word_t d,
                            input lsu_pkg::lsu_mask_t m);
        int start;
        start = fin_cnt;
        addr  = a;
        wdata = d;
        mask  = m;
        w_en  = 1'b1;
        @(posedge clk);
        #2;
        w_en = 1'b0;
        shadow[a[7:2]] = store_ref(shadow[a[7:2]], d, m, a[1:0]);
        wait_finish("store", start);
    endtask

    task automatic do_load(input lsu_pkg::lsu_word_t a);
        int start;
        start        = fin_cnt;
        exp_word     = load_ref(shadow[a[7:2]], a[1:0]);
        load_pending = 1'b1;
        addr         = a;
        r_en         = 1'b1;
        @(posedge clk);
        #2;
        r_en = 1'b0;
        wait_finish("load", start);
        load_pending = 1'b0;
    endtask

    initial begin
        lsu_pkg::lsu_word_t a;
        lsu_pkg::lsu_word_t d;
        lsu_pkg::lsu_mask_t m;
        rst          = 1'b1;
        r_en         = 1'b0;
        w_en         = 1'b0;
        addr         = '0;
        wdata        = '0;
        mask         = '0;
        lfsr         = 32'hcf9db2f3;
        load_pending = 1'b0;
        exp_word     = '0;
        fin_cnt      = 0;
        err_cnt      = 0;
        timeout_cnt  = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // quiet bus after reset
        repeat (10) @(posedge clk);
        check_count("idle after reset", fin_cnt, 0);
        #2;

        // fill every word, read each back
        for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
            a = lsu_pkg::lsu_word_t'(i) << 2;
            d = take_bits(32);
            do_store(a, d, 4'hf);
            do_load(a);
        end

        // partial stores at random offsets
        for (int k = 0; k < 40; k++) begin
            a = take_bits(32);
            d = take_bits(32);
            m = lsu_pkg::lsu_mask_t'(take_bits(4));
            do_store(a, d, m);
            a[1:0] = 2'b00;
            do_load(a);
        end

        // unaligned loads
        for (int k = 0; k < 8; k++) begin
            for (int o = 1; o < 4; o++) begin
                a      = take_bits(32);
                a[1:0] = o[1:0];
                do_load(a);
            end
        end

        $display("errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
logic/lsu_pkg.sv
logic/axi_pkg.sv
logic/axi_lite_if.sv
logic/lsu_ctrl.sv
logic/axi_sram.sv
logic/lsu_top.sv
bench/lsu_tb.sv

// File: logic/axi_lite_if.sv
interface axi_lite_if;

    axi_pkg::axi_addr_t araddr;
    logic               arvalid;
    logic               arready;

    axi_pkg::axi_data_t rdata;
    axi_pkg::axi_resp_e rresp;
    logic               rvalid;
    logic               rready;

    axi_pkg::axi_addr_t awaddr;
    logic               awvalid;
    logic               awready;

    axi_pkg::axi_data_t wdata;
    axi_pkg::axi_strb_t wstrb;
    logic               wvalid;
    logic               wready;

    axi_pkg::axi_resp_e bresp;
    logic               bvalid;
    logic               bready;

    modport master (
        output araddr, arvalid, input arready,
        input  rdata, rresp, rvalid, output rready,
        output awaddr, awvalid, input awready,
        output wdata, wstrb, wvalid, input wready,
        input  bresp, bvalid, output bready
    );

    modport slave (
        input  araddr, arvalid, output arready,
        output rdata, rresp, rvalid, input rready,
        input  awaddr, awvalid, output awready,
        input  wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready
    );

endinterface

// File: logic/axi_pkg.sv
`include "lsu_defines.svh"

package axi_pkg;

    typedef logic [`LSU_DATA_W-1:0] axi_addr_t;

    typedef logic [`LSU_DATA_W-1:0] axi_data_t;

    typedef logic [`LSU_MASK_W-1:0] axi_strb_t;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_e;

    // sram slave FSM
    typedef enum logic [2:0] {
        idle,
        read_wait,
        read_resp,
        write_wait,
        write_resp
    } sram_state_e;

endpackage

// File: logic/axi_sram.sv
`include "lsu_defines.svh"

module axi_sram (
    input  logic      clk,
    input  logic      rst,

    axi_lite_if.slave bus
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam int CNT_W = $clog2(`LSU_MEM_LAT + 1);

    axi_pkg::axi_data_t   mem [`LSU_MEM_WORDS];

    axi_pkg::sram_state_e state;
    logic [CNT_W-1:0]     cnt;
    logic [IDX_W-1:0]     idx_q;
    logic                 have_w;
    axi_pkg::axi_data_t   w_data_q;
    axi_pkg::axi_strb_t   w_strb_q;
    axi_pkg::axi_data_t   rdata_q;

    logic                 ar_hs;
    logic                 aw_hs;
    logic                 w_hs;
    logic                 mem_we;
    logic [IDX_W-1:0]     mem_idx;
    axi_pkg::axi_data_t   mem_data;
    axi_pkg::axi_strb_t   mem_strb;

    // a pending early w blocks reads until its aw shows up
    assign bus.arready = (state == axi_pkg::idle) && !have_w;
    assign bus.awready = (state == axi_pkg::idle) && !bus.arvalid;
    assign bus.wready  = ((state == axi_pkg::idle) || (state == axi_pkg::write_wait))
                         && !have_w;

    assign bus.rvalid = (state == axi_pkg::read_resp);
    assign bus.rdata  = rdata_q;
    assign bus.rresp  = axi_pkg::okay;
    assign bus.bvalid = (state == axi_pkg::write_resp);
    assign bus.bresp  = axi_pkg::okay;

    assign ar_hs = bus.arvalid && bus.arready;
    assign aw_hs = bus.awvalid && bus.awready;
    assign w_hs  = bus.wvalid && bus.wready;

    // the write lands once both address and data are known
    always_comb begin
        mem_we   = 1'b0;
        mem_idx  = idx_q;
        mem_data = w_data_q;
        mem_strb = w_strb_q;
        if (state == axi_pkg::idle && aw_hs && (w_hs || have_w)) begin
            mem_we  = 1'b1;
            mem_idx = bus.awaddr[IDX_W+1:2];
        end else if (state == axi_pkg::write_wait && w_hs) begin
            mem_we = 1'b1;
        end
        if (w_hs) begin
            mem_data = bus.wdata;
            mem_strb = bus.wstrb;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= axi_pkg::idle;
            cnt    <= '0;
            idx_q  <= '0;
            have_w <= 1'b0;
        end else begin
            case (state)
                axi_pkg::idle: begin
                    if (ar_hs) begin
                        idx_q <= bus.araddr[IDX_W+1:2];
                        cnt   <= CNT_W'(`LSU_MEM_LAT - 1);
                        state <= axi_pkg::read_wait;
                    end else if (aw_hs) begin
                        idx_q <= bus.awaddr[IDX_W+1:2];
                        cnt   <= CNT_W'(`LSU_MEM_LAT - 1);
                        state <= axi_pkg::write_wait;
                        have_w <= w_hs || have_w;
                    end else if (w_hs) begin
                        have_w <= 1'b1;
                    end
                end
                axi_pkg::read_wait: begin
                    if (cnt == '0) begin
                        state <= axi_pkg::read_resp;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                axi_pkg::read_resp: begin
                    if (bus.rready) begin
                        state <= axi_pkg::idle;
                    end
                end
                axi_pkg::write_wait: begin
                    // latency runs only after the data is in
                    if (!have_w) begin
                        if (w_hs) begin
                            have_w <= 1'b1;
                            cnt    <= CNT_W'(`LSU_MEM_LAT - 1);
                        end
                    end else if (cnt == '0) begin
                        have_w <= 1'b0;
                        state  <= axi_pkg::write_resp;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                axi_pkg::write_resp: begin
                    if (bus.bready) begin
                        state <= axi_pkg::idle;
                    end
                end
                default: state <= axi_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (w_hs) begin
            w_data_q <= bus.wdata;
            w_strb_q <= bus.wstrb;
        end
    end

    // byte merge under strobe
    always_ff @(posedge clk) begin
        if (mem_we) begin
            for (int i = 0; i < `LSU_MASK_W; i++) begin
                if (mem_strb[i]) begin
                    mem[mem_idx][8*i +: 8] <= mem_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == axi_pkg::read_wait && cnt == '0) begin
            rdata_q <= mem[idx_q];
        end
    end

endmodule

// File: logic/lsu_ctrl.sv
module lsu_ctrl (
    input  logic               clk,
    input  logic               rst,

    output lsu_pkg::lsu_word_t rdata,
    input  lsu_pkg::lsu_word_t wdata,
    input  lsu_pkg::lsu_word_t addr,
    input  lsu_pkg::lsu_mask_t mask,
    input  logic               r_en,
    input  logic               w_en,
    output logic               finish,

    axi_lite_if.master         bus
);

    lsu_pkg::lsu_off_t  off;
    lsu_pkg::lsu_word_t addr_aligned;
    logic               ar_hs;
    logic               r_hs;
    logic               aw_hs;
    logic               w_hs;
    logic               b_hs;

    assign off          = addr[1:0];
    assign addr_aligned = {addr[$bits(addr)-1:2], 2'b00};

    assign ar_hs = bus.arvalid && bus.arready;
    assign r_hs  = bus.rvalid && bus.rready;
    assign aw_hs = bus.awvalid && bus.awready;
    assign w_hs  = bus.wvalid && bus.wready;
    assign b_hs  = bus.bvalid && bus.bready;

    // read side
    always_ff @(posedge clk) begin
        if (r_en) begin
            bus.araddr <= addr_aligned;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.arvalid <= 1'b0;
        end else if (ar_hs) begin
            bus.arvalid <= 1'b0;
        end else if (r_en) begin
            bus.arvalid <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.rready <= 1'b0;
        end else if (r_hs) begin
            bus.rready <= 1'b0;
        end else if (ar_hs) begin
            bus.rready <= 1'b1;
        end
    end

    // offset is taken live, addr is held by the core until finish
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (r_hs) begin
            rdata <= bus.rdata >> {off, 3'b000};
        end
    end

    // write side, address and data go out together
    always_ff @(posedge clk) begin
        if (w_en) begin
            bus.awaddr <= addr_aligned;
            // bytes pushed past the top lane are lost
            bus.wdata  <= wdata << {off, 3'b000};
            bus.wstrb  <= mask << off;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.awvalid <= 1'b0;
        end else if (aw_hs) begin
            bus.awvalid <= 1'b0;
        end else if (w_en) begin
            bus.awvalid <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.wvalid <= 1'b0;
        end else if (w_hs) begin
            bus.wvalid <= 1'b0;
        end else if (w_en) begin
            bus.wvalid <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.bready <= 1'b0;
        end else if (b_hs) begin
            bus.bready <= 1'b0;
        end else if (aw_hs) begin
            bus.bready <= 1'b1;
        end
    end

    // one cycle after the closing handshake.
    // ready drops on the handshake, so this never lasts two cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            finish <= 1'b0;
        end else begin
            finish <= r_hs || b_hs;
        end
    end

endmodule

// File: logic/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// core word and bus data width
`define LSU_DATA_W 32

// one enable bit per byte of a word
`define LSU_MASK_W 4

// slave memory depth in words
`define LSU_MEM_WORDS 64

// cycles from request accept to response valid
`define LSU_MEM_LAT 2

`endif

// File: logic/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    // core side view of a memory access

    typedef logic [`LSU_DATA_W-1:0] lsu_word_t;

    typedef logic [`LSU_MASK_W-1:0] lsu_mask_t;

    // byte position inside a word
    typedef logic [1:0] lsu_off_t;

endpackage

// File: logic/lsu_top.sv
module lsu_top (
    input  logic               clk,
    input  logic               rst,

    output lsu_pkg::lsu_word_t rdata,
    input  lsu_pkg::lsu_word_t wdata,
    input  lsu_pkg::lsu_word_t addr,
    input  lsu_pkg::lsu_mask_t mask,
    input  logic               r_en,
    input  logic               w_en,
    output logic               finish
);

    axi_lite_if bus_if ();

    // master side
    lsu_ctrl u_ctrl (
        .clk    (clk),
        .rst    (rst),
        .rdata  (rdata),
        .wdata  (wdata),
        .addr   (addr),
        .mask   (mask),
        .r_en   (r_en),
        .w_en   (w_en),
        .finish (finish),
        .bus    (bus_if.master)
    );

    // memory behind the bus
    axi_sram u_sram (
        .clk (clk),
        .rst (rst),
        .bus (bus_if.slave)
    );

endmodule
